// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing --assert -Wno-fatal
TOP       = tb_corr
FILELIST  = list.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	@./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	else \
		echo "simulation ok"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== cmac_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "corr_defines.svh"

module cmac_unit import corr_pkg::*; (
   input  wire       clk,
   input  wire       rst,          // sync, active low
   input  rd_req_t   i_rd,         // request, same cycle as buffer read
   input  smp_pair_t i_row_pair,   // buffer data, one cycle after request
   input  smp_pair_t i_col_pair,
   output acc_res_t  o_res
);

   localparam int SW   = `CORR_SW;
   localparam int PW   = 2 * SW;                              // product width
   localparam int ACCW = `CORR_ACCW;
   localparam int IW   = $clog2(`CORR_ROWS * `CORR_ROWS);

   //////////////////////////////////////////////////
   // stage 1, flags wait for buffer read
   //////////////////////////////////////////////////
   logic          s1_vld, s1_first, s1_last;
   logic [IW-1:0] s1_idx;

   always_ff @(posedge clk) begin
      if (!rst) begin
         s1_vld <= 1'b0;
      end else begin
         s1_vld <= i_rd.valid;
      end
      s1_first <= i_rd.first;
      s1_last  <= i_rd.last;
      s1_idx   <= i_rd.idx;
   end

   //////////////////////////////////////////////////
   // stage 2, eight real products
   //////////////////////////////////////////////////
   logic                 s2_vld, s2_first, s2_last;
   logic [IW-1:0]        s2_idx;
   logic signed [PW-1:0] c_rr, c_ii, c_ir, c_ri;  // j * conj(z)
   logic signed [PW-1:0] a_rr, a_ii, a_ir, a_ri;  // j * conj(j)

   always_ff @(posedge clk) begin
      if (!rst) begin
         s2_vld <= 1'b0;
      end else begin
         s2_vld <= s1_vld;
      end
      s2_first <= s1_first;
      s2_last  <= s1_last;
      s2_idx   <= s1_idx;
      c_rr <= i_row_pair.j.re * i_col_pair.z.re;
      c_ii <= i_row_pair.j.im * i_col_pair.z.im;
      c_ir <= i_row_pair.j.im * i_col_pair.z.re;
      c_ri <= i_row_pair.j.re * i_col_pair.z.im;
      a_rr <= i_row_pair.j.re * i_col_pair.j.re;
      a_ii <= i_row_pair.j.im * i_col_pair.j.im;
      a_ir <= i_row_pair.j.im * i_col_pair.j.re;
      a_ri <= i_row_pair.j.re * i_col_pair.j.im;
   end

   //////////////////////////////////////////////////
   // stage 3, accumulate
   //////////////////////////////////////////////////
   logic signed [ACCW-1:0] t_cr, t_ci, t_ar, t_ai;   // this term
   logic signed [ACCW-1:0] acc_cr, acc_ci, acc_ar, acc_ai;
   logic                   res_vld;
   logic [IW-1:0]          res_idx;

   assign t_cr = ACCW'(c_rr) + ACCW'(c_ii);  // re: jr*zr + ji*zi
   assign t_ci = ACCW'(c_ir) - ACCW'(c_ri);  // im: ji*zr - jr*zi
   assign t_ar = ACCW'(a_rr) + ACCW'(a_ii);
   assign t_ai = ACCW'(a_ir) - ACCW'(a_ri);  // zero on the diagonal

   always_ff @(posedge clk) begin
      if (!rst) begin
         res_vld <= 1'b0;
      end else begin
         res_vld <= s2_vld & s2_last;          // sum complete
      end
      if (s2_vld) begin
         res_idx <= s2_idx;
         acc_cr  <= s2_first ? t_cr : acc_cr + t_cr;
         acc_ci  <= s2_first ? t_ci : acc_ci + t_ci;
         acc_ar  <= s2_first ? t_ar : acc_ar + t_ar;
         acc_ai  <= s2_first ? t_ai : acc_ai + t_ai;
      end
   end

   assign o_res.valid    = res_vld;
   assign o_res.idx      = res_idx;
   assign o_res.cross_re = acc_cr;
   assign o_res.cross_im = acc_ci;
   assign o_res.auto_re  = acc_ar;
   assign o_res.auto_im  = acc_ai;

endmodule

`default_nettype wire

// ==== corr_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "corr_defines.svh"

module corr_chk import corr_pkg::*; (
   input wire      clk,
   input wire      rst,          // sync, active low
   input wire      smp_ready,    // capture open
   input wire      busy,         // sequencer walking
   input rd_req_t  rd,           // sequencer request
   input acc_res_t res,          // mac result
   input apb_req_t apb,
   input apb_rsp_t apb_rsp
);

   localparam logic [`CORR_APB_W-1:0] WIN = 8 * `CORR_ROWS * `CORR_ROWS; // bytes per matrix

   logic in_cross;               // inside cross window
   logic in_auto;                // inside auto window
   logic mapped;                 // word address in the apb map

   assign in_cross = (apb.paddr >= `CORR_BASE_CROSS) && (apb.paddr < `CORR_BASE_CROSS + WIN);
   assign in_auto  = (apb.paddr >= `CORR_BASE_AUTO) && (apb.paddr < `CORR_BASE_AUTO + WIN);
   assign mapped   = (apb.paddr == `CORR_ADDR_STATUS) || (apb.paddr == `CORR_ADDR_CTRL)
                     || ((in_cross || in_auto) && (apb.paddr[1:0] == 2'b00));

   //////////////////////////////////////////////////
   // handshakes and pipeline flags
   //////////////////////////////////////////////////
   a_ready_busy : assert property (@(posedge clk) disable iff (!rst)
      !(smp_ready && busy))
      else $error("capture ready while the sequencer is busy");

   a_res_after_last : assert property (@(posedge clk) disable iff (!rst)
      res.valid |-> $past(rd.valid && rd.last, 3))  // request, product, sum
      else $error("result valid without a last request three cycles earlier");

   a_slverr_access : assert property (@(posedge clk) disable iff (!rst)
      apb_rsp.pslverr == (apb.psel && apb.penable && !mapped))
      else $error("pslverr does not match an access phase to an unmapped address");

endmodule

`default_nettype wire

// ==== corr_defines.svh ====
`ifndef CORR_DEFINES_SVH
`define CORR_DEFINES_SVH

//////////////////////////////////////////////////
// array geometry
//////////////////////////////////////////////////
`define CORR_ROWS        4                          // antenna rows
`define CORR_NSAMP       8                          // samples per row
`define CORR_DEPTH       (`CORR_ROWS * `CORR_NSAMP) // pairs held in buffer, 32

//////////////////////////////////////////////////
// arithmetic widths
//////////////////////////////////////////////////
`define CORR_SW          16                         // sample component, 8 frac bits
`define CORR_ACCW        40                         // accumulator width
`define CORR_FRAC        8                          // bits dropped when stored

//////////////////////////////////////////////////
// apb map
//////////////////////////////////////////////////
`define CORR_APB_W       32                         // apb addr and data width
`define CORR_ADDR_STATUS 32'h0000_0000              // done bit0, busy bit1
`define CORR_ADDR_CTRL   32'h0000_0004              // bit0 write clears
`define CORR_BASE_CROSS  32'h0000_0100              // C[r][c], re then im
`define CORR_BASE_AUTO   32'h0000_0200              // A[r][c], re then im

`endif

// ==== corr_input.txt ====
// samples, 32 lines: z_re z_im j_re j_im, 16-bit hex, row 0 k 0..7 then row 1 ...
// expected, 16 lines: r c cross_re cross_im auto_re auto_im, 32-bit hex
0020 0000 0040 0000
ffe0 0000 ffc0 0000
0020 0000 0040 0000
ffe0 0000 ffc0 0000
0020 0000 0040 0000
ffe0 0000 ffc0 0000
0020 0000 0040 0000
ffe0 0000 ffc0 0000
0010 0010 0000 0040
fff0 fff0 0000 ffc0
0010 0010 0000 0040
fff0 fff0 0000 ffc0
0010 0010 0000 0040
fff0 fff0 0000 ffc0
0010 0010 0000 0040
fff0 fff0 0000 ffc0
fff0 0008 0020 ffe0
0010 fff8 ffe0 0020
fff0 0008 0020 ffe0
0010 fff8 ffe0 0020
fff0 0008 0020 ffe0
0010 fff8 ffe0 0020
fff0 0008 0020 ffe0
0010 fff8 ffe0 0020
0000 ffe8 ffd1 0010
0000 0018 002f fff0
0000 ffe8 ffd1 0010
0000 0018 002f fff0
0000 ffe8 ffd1 0010
0000 0018 002f fff0
0000 ffe8 ffd1 0010
0000 0018 002f fff0
0 0 00000040 00000000 00000080 00000000
0 1 00000020 ffffffe0 00000000 ffffff80
0 2 ffffffe0 fffffff0 00000040 00000040
0 3 00000000 00000030 ffffffa2 ffffffe0
1 0 00000000 00000040 00000000 00000080
1 1 00000020 00000020 00000080 00000000
1 2 00000010 ffffffe0 ffffffc0 00000040
1 3 ffffffd0 00000000 00000020 ffffffa2
2 0 00000020 ffffffe0 00000040 ffffffc0
2 1 00000000 ffffffe0 ffffffc0 ffffffc0
2 2 ffffffe8 00000008 00000040 00000000
2 3 00000018 00000018 ffffffc1 0000001f
3 0 ffffffd1 00000010 ffffffa2 00000020
3 1 fffffff0 0000001f 00000020 0000005e
3 2 0000001b 00000003 ffffffc1 ffffffe1
3 3 fffffff4 ffffffdc 0000004d 00000000

// ==== corr_pkg.sv ====
`default_nettype none

`include "corr_defines.svh"

package corr_pkg;

   typedef struct packed {
      logic signed [`CORR_SW-1:0] re;  // real part
      logic signed [`CORR_SW-1:0] im;  // imag part
   } cplx_t;

   typedef struct packed {
      cplx_t z;                         // reference sample
      cplx_t j;                         // channel sample
   } smp_pair_t;

   typedef struct packed {
      logic      valid;
      smp_pair_t pair;
   } smp_in_t;

   typedef struct packed {
      logic                                     valid;
      logic                                     first;     // first term of a sum
      logic                                     last;      // last term of a sum
      logic [$clog2(`CORR_DEPTH)-1:0]           row_addr;  // r*nsamp+k
      logic [$clog2(`CORR_DEPTH)-1:0]           col_addr;  // c*nsamp+k
      logic [$clog2(`CORR_ROWS*`CORR_ROWS)-1:0] idx;       // r*4+c
   } rd_req_t;

   typedef struct packed {
      logic                                     valid;
      logic [$clog2(`CORR_ROWS*`CORR_ROWS)-1:0] idx;
      logic signed [`CORR_ACCW-1:0]             cross_re;
      logic signed [`CORR_ACCW-1:0]             cross_im;
      logic signed [`CORR_ACCW-1:0]             auto_re;
      logic signed [`CORR_ACCW-1:0]             auto_im;
   } acc_res_t;

   typedef struct packed {
      logic                  psel;
      logic                  penable;
      logic                  pwrite;
      logic [`CORR_APB_W-1:0] paddr;
      logic [`CORR_APB_W-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [`CORR_APB_W-1:0] prdata;
      logic                  pready;
      logic                  pslverr;
   } apb_rsp_t;

endpackage

`default_nettype wire

// ==== corr_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "corr_defines.svh"

module corr_sequencer import corr_pkg::*; (
   input  wire     clk,
   input  wire     rst,         // sync, active low
   input  wire     i_full,      // buffer holds a full set
   input  wire     i_clear,     // abort and rearm
   output rd_req_t o_rd,        // one request per cycle while busy
   output logic    o_busy
);

   localparam int RW = $clog2(`CORR_ROWS);
   localparam int KW = $clog2(`CORR_NSAMP);

   logic          run;          // walk in progress
   logic [RW-1:0] row;          // outer loop
   logic [RW-1:0] col;          // middle loop
   logic [KW-1:0] k;            // inner loop, sample index
   logic          term_last;    // k at last sample
   logic          walk_end;     // final term of final result

   assign term_last = &k;
   assign walk_end  = term_last & (&col) & (&row);

   //////////////////////////////////////////////////
   // row / column / sample walk
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst || i_clear) begin
         run <= 1'b0;
         row <= '0;
         col <= '0;
         k   <= '0;
      end else if (!run) begin
         if (i_full) begin
            run <= 1'b1;                 // first request next cycle
         end
      end else begin
         k <= k + 1'b1;                  // wraps to 0 after last sample
         if (term_last) begin
            col <= col + 1'b1;
            if (&col) begin
               row <= row + 1'b1;
            end
         end
         if (walk_end) begin
            run <= 1'b0;                 // 16 sums done, counters back at 0
         end
      end
   end

   //////////////////////////////////////////////////
   // request fields
   //////////////////////////////////////////////////
   assign o_rd.valid    = run;
   assign o_rd.first    = run & (k == '0);  // load accumulators
   assign o_rd.last     = run & term_last;  // present result
   assign o_rd.row_addr = {row, k};         // r*nsamp + k
   assign o_rd.col_addr = {col, k};         // c*nsamp + k
   assign o_rd.idx      = {row, col};       // r*4 + c

   assign o_busy = run;

endmodule

`default_nettype wire

// ==== corr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module corr_top import corr_pkg::*; (
   input  wire      clk,
   input  wire      rst,          // sync, active low
   input  smp_in_t  i_smp,        // z and j capture stream
   output logic     o_smp_ready,
   input  apb_req_t i_apb,
   output apb_rsp_t o_apb
);

   logic      full;               // buffer loaded
   logic      clear;              // control write
   logic      busy;               // sequencer walking
   rd_req_t   rd;                 // buffer read + mac flags
   smp_pair_t row_pair;
   smp_pair_t col_pair;
   acc_res_t  res;                // finished sum

   //////////////////////////////////////////////////
   // capture and walk
   //////////////////////////////////////////////////
   sample_buffer u_buf (
      .clk         (clk),
      .rst         (rst),
      .i_smp       (i_smp),
      .i_clear     (clear),
      .i_rd        (rd),
      .o_smp_ready (o_smp_ready),
      .o_full      (full),
      .o_row_pair  (row_pair),
      .o_col_pair  (col_pair)
   );

   corr_sequencer u_seq (
      .clk     (clk),
      .rst     (rst),
      .i_full  (full),
      .i_clear (clear),
      .o_rd    (rd),
      .o_busy  (busy)
   );

   //////////////////////////////////////////////////
   // arithmetic and register file
   //////////////////////////////////////////////////
   cmac_unit u_mac (
      .clk        (clk),
      .rst        (rst),
      .i_rd       (rd),
      .i_row_pair (row_pair),
      .i_col_pair (col_pair),
      .o_res      (res)
   );

   result_regs u_regs (
      .clk     (clk),
      .rst     (rst),
      .i_res   (res),
      .i_busy  (busy),
      .i_apb   (i_apb),
      .o_apb   (o_apb),
      .o_clear (clear)
   );

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
corr_pkg.sv
sample_buffer.sv
corr_sequencer.sv
cmac_unit.sv
result_regs.sv
corr_top.sv
corr_chk.sv
tb_corr.sv

// ==== result_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "corr_defines.svh"

module result_regs import corr_pkg::*; (
   input  wire      clk,
   input  wire      rst,        // sync, active low
   input  acc_res_t i_res,      // finished sums from mac
   input  wire      i_busy,     // sequencer walking
   input  apb_req_t i_apb,
   output apb_rsp_t o_apb,
   output logic     o_clear     // restart capture
);

   localparam int NRES = `CORR_ROWS * `CORR_ROWS;      // 16 results per matrix
   localparam int IW   = $clog2(NRES);
   localparam int WIN  = 8 * NRES;                     // bytes per matrix window
   localparam int DW   = `CORR_APB_W;
   localparam int LO   = `CORR_FRAC;                   // lsb kept
   localparam int HI   = `CORR_FRAC + DW - 1;          // msb kept

   logic [2*DW-1:0] cross_mem [NRES];  // {im, re}
   logic [2*DW-1:0] auto_mem  [NRES];
   logic [IW:0]     res_cnt;           // results stored
   logic            done;

   //////////////////////////////////////////////////
   // result store
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (i_res.valid) begin
         // slice is a shift right with floor rounding
         cross_mem[i_res.idx] <= {i_res.cross_im[HI:LO], i_res.cross_re[HI:LO]};
         auto_mem[i_res.idx]  <= {i_res.auto_im[HI:LO], i_res.auto_re[HI:LO]};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst || o_clear) begin
         res_cnt <= '0;
         done    <= 1'b0;
      end else if (i_res.valid) begin
         res_cnt <= res_cnt + 1'b1;
         if (res_cnt == (IW+1)'(NRES - 1)) begin
            done <= 1'b1;              // 16th result in, held till clear
         end
      end
   end

   //////////////////////////////////////////////////
   // apb decode
   //////////////////////////////////////////////////
   logic          acc_ph;              // access phase
   logic          sel_status, sel_ctrl, sel_cross, sel_auto;
   logic          hit;
   logic [IW-1:0] rd_idx;
   logic          rd_hi;               // imag half
   logic [DW-1:0] aligned;

   assign acc_ph     = i_apb.psel & i_apb.penable;
   assign aligned    = i_apb.paddr & ~DW'(WIN - 1);
   assign sel_status = i_apb.paddr == `CORR_ADDR_STATUS;
   assign sel_ctrl   = i_apb.paddr == `CORR_ADDR_CTRL;
   assign sel_cross  = (aligned == `CORR_BASE_CROSS) & (i_apb.paddr[1:0] == 2'b00);
   assign sel_auto   = (aligned == `CORR_BASE_AUTO) & (i_apb.paddr[1:0] == 2'b00);
   assign hit        = sel_status | sel_ctrl | sel_cross | sel_auto;
   assign rd_idx     = i_apb.paddr[IW+2:3];  // 8 bytes per entry
   assign rd_hi      = i_apb.paddr[2];

   always_comb begin
      o_apb.prdata = '0;
      if (sel_status) begin
         o_apb.prdata = {{(DW-2){1'b0}}, i_busy, done};
      end else if (sel_cross) begin
         o_apb.prdata = rd_hi ? cross_mem[rd_idx][2*DW-1:DW] : cross_mem[rd_idx][DW-1:0];
      end else if (sel_auto) begin
         o_apb.prdata = rd_hi ? auto_mem[rd_idx][2*DW-1:DW] : auto_mem[rd_idx][DW-1:0];
      end
   end

   assign o_apb.pready  = 1'b1;                 // no wait states
   assign o_apb.pslverr = acc_ph & ~hit;        // unmapped address

   // write 1 to ctrl bit0, clears done and reopens capture
   assign o_clear = acc_ph & i_apb.pwrite & sel_ctrl & i_apb.pwdata[0];

endmodule

`default_nettype wire

// ==== sample_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "corr_defines.svh"

module sample_buffer import corr_pkg::*; (
   input  wire       clk,
   input  wire       rst,           // sync, active low
   input  smp_in_t   i_smp,         // capture stream
   input  wire       i_clear,       // restart capture
   input  rd_req_t   i_rd,          // read request from sequencer
   output logic      o_smp_ready,
   output logic      o_full,        // one cycle after last pair
   output smp_pair_t o_row_pair,    // pair at row address
   output smp_pair_t o_col_pair     // pair at column address
);

   localparam int AW = $clog2(`CORR_DEPTH);

   smp_pair_t      mem [`CORR_DEPTH]; // z and j side by side
   logic [AW:0]    wr_cnt;            // pairs taken so far
   logic           wr_en;

   assign o_smp_ready = ~wr_cnt[AW];          // msb set once all pairs taken
   assign wr_en       = i_smp.valid & o_smp_ready;

   //////////////////////////////////////////////////
   // write side
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst || i_clear) begin
         wr_cnt <= '0;
         o_full <= 1'b0;
      end else begin
         o_full <= wr_en & (&wr_cnt[AW-1:0]); // pulse on last address
         if (wr_en) begin
            wr_cnt <= wr_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_cnt[AW-1:0]] <= i_smp.pair;   // row-major, sample fastest
      end
   end

   //////////////////////////////////////////////////
   // two registered read ports
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (i_rd.valid) begin
         o_row_pair <= mem[i_rd.row_addr];    // j[r,k] and z[r,k]
         o_col_pair <= mem[i_rd.col_addr];    // z[c,k] and j[c,k]
      end
   end

endmodule

`default_nettype wire

// ==== tb_corr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "corr_defines.svh"

module tb_corr import corr_pkg::*; ();

   localparam int NRES     = `CORR_ROWS * `CORR_ROWS;
   localparam int ROUND_CY = `CORR_DEPTH + 8 + NRES * `CORR_NSAMP + 4 + 2 * 2 * NRES * 2 + 50;
   localparam int WDOG_CY  = 2 * ROUND_CY + 1000;           // two rounds plus margin

   logic      clk;
   logic      rst;
   smp_in_t   smp;
   logic      o_smp_ready;
   apb_req_t  apb;
   apb_rsp_t  apb_rsp;

   smp_pair_t   pairs   [`CORR_DEPTH];  // stimulus from file
   logic [31:0] exp_mem [4*NRES];       // cross re, cross im, auto re, auto im
   logic [31:0] got_mem [4*NRES];       // first round readback
   logic [31:0] lfsr;
   int          error_count;
   int          check_count;

   corr_top i_dut (
      .clk         (clk),
      .rst         (rst),
      .i_smp       (smp),
      .o_smp_ready (o_smp_ready),
      .i_apb       (apb),
      .o_apb       (apb_rsp)
   );

   bind corr_top corr_chk u_chk (
      .clk (clk), .rst (rst), .smp_ready (o_smp_ready), .busy (busy),
      .rd (rd), .res (res), .apb (i_apb), .apb_rsp (o_apb)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;                // 10 ns period
   end

   initial begin
      repeat (WDOG_CY) @(posedge clk);
      $display("Error at %0t: watchdog expired, the DUT never finished", $time);
      $display("Testbench failed");
      $finish;
   end

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);  // galois, right shift
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};         // one step per bit
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic check_word(input string what, input int idx,
                             input logic [31:0] got, input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Mismatch at %0t: %s[%0d] got %h expected %h", $time, what, idx, got, exp);
      end
   endtask

   task automatic check_pready(input logic [31:0] addr);
      check_count++;
      if (apb_rsp.pready !== 1'b1) begin
         error_count++;
         $display("Error at %0t: pready low in the access phase to %h", $time, addr);
      end
   endtask

   // all tasks start and end 1 ns after a rising edge
   task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic err);
      apb.psel    = 1'b1;
      apb.penable = 1'b0;
      apb.pwrite  = 1'b0;
      apb.paddr   = addr;
      @(posedge clk);
      #1 apb.penable = 1'b1;
      #4;                                   // mid cycle, prdata settled
      data = apb_rsp.prdata;
      err  = apb_rsp.pslverr;
      check_pready(addr);
      @(posedge clk);
      #1 apb.psel = 1'b0;
      apb.penable = 1'b0;
   endtask

   task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
      apb.psel    = 1'b1;
      apb.penable = 1'b0;
      apb.pwrite  = 1'b1;
      apb.paddr   = addr;
      apb.pwdata  = data;
      @(posedge clk);
      #1 apb.penable = 1'b1;
      #4;
      check_pready(addr);
      @(posedge clk);
      #1 apb.psel = 1'b0;
      apb.penable = 1'b0;
      apb.pwrite  = 1'b0;
   endtask

   task automatic send_pair(input smp_pair_t p);
      smp.valid = 1'b1;
      smp.pair  = p;
      #4;
      while (!o_smp_ready) begin            // hold until buffer takes it
         @(posedge clk);
         #5;
      end
      @(posedge clk);
      #1 smp.valid = 1'b0;
   endtask

   task automatic run_round(input int round);
      logic [31:0] d;
      logic [31:0] r0;
      logic [31:0] r1;
      logic        e;
      logic        seen_busy;
      int          base;
      for (int i = 0; i < `CORR_DEPTH; i++) begin
         send_pair(pairs[i]);
      end
      #4;
      check_count++;
      if (o_smp_ready) begin
         error_count++;
         $display("Error at %0t: capture still ready after %0d pairs", $time, `CORR_DEPTH);
      end
      @(posedge clk);
      #1;
      for (int i = 0; i < 4; i++) begin     // offered after full, must be dropped
         take_bits(32, r0);
         take_bits(32, r1);
         smp.valid = 1'b1;
         smp.pair  = {r0, r1};
         @(posedge clk);
         #1;
      end
      smp.valid = 1'b0;
      d = '0;
      seen_busy = 1'b0;
      while (!d[0]) begin
         apb_read(`CORR_ADDR_STATUS, d, e);
         seen_busy = seen_busy | d[1];
      end
      check_word("status_done", round, d, 32'h1);   // walk over, busy low
      check_count++;
      if (!seen_busy) begin
         error_count++;
         $display("Error at %0t: status never showed busy during the walk", $time);
      end
      for (int m = 0; m < 2; m++) begin
         base = (m == 0) ? `CORR_BASE_CROSS : `CORR_BASE_AUTO;
         for (int i = 0; i < NRES; i++) begin
            apb_read(base + 8 * i, r0, e);
            apb_read(base + 8 * i + 4, r1, e);
            check_word(m == 0 ? "cross_re" : "auto_re", i, r0, exp_mem[4*i + 2*m]);
            check_word(m == 0 ? "cross_im" : "auto_im", i, r1, exp_mem[4*i + 2*m + 1]);
            if (m == 1 && i % 5 == 0) begin // diagonal r == c
               check_word("auto_diag_im", i, r1, 32'h0);
            end
            if (round == 0) begin
               got_mem[4*i + 2*m]     = r0;
               got_mem[4*i + 2*m + 1] = r1;
            end else begin
               check_word("round_re", 4*i + 2*m, r0, got_mem[4*i + 2*m]);
               check_word("round_im", 4*i + 2*m + 1, r1, got_mem[4*i + 2*m + 1]);
            end
         end
      end
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////
   initial begin
      int          fd;
      int          n;
      int          r;
      int          c;
      string       line;
      logic [15:0] zr, zi, jr, ji;
      logic [31:0] cr, ci, ar, ai;
      logic [31:0] d;
      logic        e;
      error_count = 0;
      check_count = 0;
      lfsr        = 32'h6ce1;
      rst         = 1'b0;
      smp         = '0;
      apb         = '0;
      fd = $fopen("corr_input.txt", "r");
      if (fd == 0) begin
         error_count++;
         $display("Error: cannot open corr_input.txt");
      end else begin
         n = $fgets(line, fd);              // two column header lines
         n = $fgets(line, fd);
         for (int i = 0; i < `CORR_DEPTH; i++) begin
            n = $fscanf(fd, "%h %h %h %h\n", zr, zi, jr, ji);
            if (n != 4) begin
               error_count++;
               $display("Error: sample line %0d of corr_input.txt is malformed", i);
            end
            pairs[i] = {zr, zi, jr, ji};
         end
         for (int i = 0; i < NRES; i++) begin
            n = $fscanf(fd, "%d %d %h %h %h %h\n", r, c, cr, ci, ar, ai);
            if (n != 6) begin
               error_count++;
               $display("Error: expected line %0d of corr_input.txt is malformed", i);
            end
            exp_mem[4*(4*r + c)]     = cr;
            exp_mem[4*(4*r + c) + 1] = ci;
            exp_mem[4*(4*r + c) + 2] = ar;
            exp_mem[4*(4*r + c) + 3] = ai;
         end
         $fclose(fd);
      end

      repeat (2) @(posedge clk);
      #1 rst = 1'b1;

      apb_read(`CORR_ADDR_STATUS, d, e);
      check_word("status_after_reset", 0, d, 32'h0);
      check_count++;
      if (!o_smp_ready) begin
         error_count++;
         $display("Error at %0t: capture not ready after reset", $time);
      end

      run_round(0);

      apb_read(32'h0000_0080, d, e);         // hole in the map
      check_count++;
      if (!e) begin
         error_count++;
         $display("Error at %0t: unmapped read gave no slave error", $time);
      end

      apb_write(`CORR_ADDR_CTRL, 32'h1);
      apb_read(`CORR_ADDR_STATUS, d, e);
      check_word("status_after_clear", 0, d, 32'h0);
      run_round(1);

      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
